//--- Makefile
# Verilator build and run for the pipeline front end.
# Override on the command line, e.g. make sim LOG=run.log

TOP ?= pipeTb
FILELIST ?= verilog.f
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	verilator $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG) || ! grep -q "All tests passed" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- hdl/decodeLatch.sv
`timescale 1ns/100ps

module decodeLatch (
	input logic clk,
	input logic rstN,
	input logic stall,
	input logic flush,
	input logic [pipePkg::addrW-1:0] instr,
	input logic [pipePkg::addrW-1:0] fetchPc,
	input logic fetchExc,
	input pipePkg::excCodeT fetchExcCode,
	output logic decValid,
	output logic [pipePkg::addrW-1:0] decPc,
	output pipePkg::opcodeT decOp,
	output logic [pipePkg::regW-1:0] decRs,
	output logic [pipePkg::regW-1:0] decRt,
	output logic [pipePkg::regW-1:0] decRd,
	output logic [pipePkg::regW-1:0] decShamt,
	output logic [5:0] decFunc,
	output logic [15:0] decImm,
	output logic decExc,
	output pipePkg::excCodeT decExcCode
);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			decValid <= 1'b0;
			decPc <= '0;
			decOp <= pipePkg::special;
			decRs <= '0;
			decRt <= '0;
			decRd <= '0;
			decShamt <= '0;
			decFunc <= '0;
			decImm <= '0;
			decExc <= 1'b0;
			decExcCode <= pipePkg::excNone;
		end else if (flush) begin
			decValid <= 1'b0; // The slot becomes a bubble.
			decPc <= '0;
			decOp <= pipePkg::special;
			decRs <= '0;
			decRt <= '0;
			decRd <= '0;
			decShamt <= '0;
			decFunc <= '0;
			decImm <= '0;
			decExc <= 1'b0;
			decExcCode <= pipePkg::excNone;
		end else if (!stall) begin
			decValid <= 1'b1;
			decPc <= fetchPc;
			decOp <= pipePkg::opcodeT'(instr[31:26]); // Unlisted opcodes pass through as raw bits.
			decRs <= instr[25:21];
			decRt <= instr[20:16];
			decRd <= instr[15:11];
			decShamt <= instr[10:6];
			decFunc <= instr[5:0];
			decImm <= instr[15:0];
			decExc <= fetchExc;
			decExcCode <= fetchExcCode;
		end
	end

	flushKillsDecode: assert property (
		@(posedge clk) disable iff (!rstN)
		flush |=> !decValid
	) else $error("decode slot still valid after a flush.");

endmodule

//--- hdl/executeLatch.sv
`timescale 1ns/100ps

module executeLatch (
	input logic clk,
	input logic rstN,
	input logic stall,
	input logic flush,
	input logic decValid,
	input logic [pipePkg::addrW-1:0] decPc,
	input pipePkg::opcodeT decOp,
	input logic [pipePkg::regW-1:0] decRs,
	input logic [pipePkg::regW-1:0] decRt,
	input logic [pipePkg::regW-1:0] decRd,
	input logic [pipePkg::regW-1:0] decShamt,
	input logic [5:0] decFunc,
	input logic [15:0] decImm,
	input logic decExc,
	input pipePkg::excCodeT decExcCode,
	output logic exValid,
	output logic [pipePkg::addrW-1:0] exPc,
	output pipePkg::opClassT exClass,
	output logic [pipePkg::regW-1:0] exRs,
	output logic [pipePkg::regW-1:0] exRt,
	output logic [pipePkg::regW-1:0] exRd,
	output logic [pipePkg::regW-1:0] exShamt,
	output logic [5:0] exFunc,
	output logic [15:0] exImm,
	output logic exExc,
	output pipePkg::excCodeT exExcCode,
	output logic exStall
);

	pipePkg::opClassT opClass;
	logic mergedExc;
	pipePkg::excCodeT mergedCode;

	always_comb begin
		case (decOp)
			pipePkg::special, pipePkg::addiu, pipePkg::lui: opClass = pipePkg::classAlu;
			pipePkg::lw: opClass = pipePkg::classLoad;
			pipePkg::sw: opClass = pipePkg::classStore;
			pipePkg::beq: opClass = pipePkg::classBranch;
			pipePkg::j: opClass = pipePkg::classJump;
			default: opClass = pipePkg::classNone;
		endcase
	end

	// An exception from fetch is older than RI, so it keeps its code.
	always_comb begin
		mergedExc = 1'b0;
		mergedCode = pipePkg::excNone;
		if (decValid && decExc) begin
			mergedExc = 1'b1;
			mergedCode = decExcCode;
		end else if (decValid && opClass == pipePkg::classNone) begin
			mergedExc = 1'b1;
			mergedCode = pipePkg::excRI;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exValid <= 1'b0;
			exPc <= '0;
			exClass <= pipePkg::classNone;
			{exRs, exRt, exRd, exShamt} <= '0;
			exFunc <= '0;
			exImm <= '0;
			exExc <= 1'b0;
			exExcCode <= pipePkg::excNone;
			exStall <= 1'b0;
		end else if (flush) begin
			exValid <= 1'b0;
			exPc <= '0;
			exClass <= pipePkg::classNone;
			{exRs, exRt, exRd, exShamt} <= '0;
			exFunc <= '0;
			exImm <= '0;
			exExc <= 1'b0;
			exExcCode <= pipePkg::excNone;
			exStall <= 1'b0;
		end else if (!stall) begin
			exValid <= decValid;
			exPc <= decPc;
			exClass <= opClass;
			exRs <= decRs;
			exRt <= decRt;
			exRd <= decRd;
			exShamt <= decShamt;
			exFunc <= decFunc;
			exImm <= decImm;
			exExc <= mergedExc;
			exExcCode <= mergedCode;
			exStall <= 1'b0;
		end else begin
			exStall <= 1'b1; // Downstream sees a held entry, not a new one.
		end
	end

	stallMarkerCause: assert property (
		@(posedge clk) disable iff (!rstN)
		$rose(exStall) |-> $past(stall)
	) else $error("exStall rose without a stall.");

endmodule

//--- hdl/fetchStage.sv
`timescale 1ns/100ps

module fetchStage (
	input logic clk,
	input logic rstN,
	input logic stall,
	input logic flush,
	input logic [pipePkg::addrW-1:0] redirectPc,
	output logic [pipePkg::addrW-1:0] pc,
	output logic fetchExc,
	output pipePkg::excCodeT fetchExcCode
);

	logic misaligned;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= pipePkg::resetPc;
		end else if (flush) begin
			pc <= redirectPc; // Redirect wins over a stall.
		end else if (!stall) begin
			pc <= pc + pipePkg::pcStep;
		end
	end

	assign misaligned = (pc[1:0] != 2'b00); // Words must be 4-byte aligned.

	always_comb begin
		fetchExc = misaligned;
		fetchExcCode = misaligned ? pipePkg::excAdEL : pipePkg::excNone;
	end

	redirectTaken: assert property (
		@(posedge clk) disable iff (!rstN)
		flush |=> (pc == $past(redirectPc))
	) else $error("pc did not follow the redirect address.");

endmodule

//--- hdl/pipePkg.sv
package pipePkg;

	localparam int addrW = 32;
	localparam int regW = 5;
	localparam int excW = 5;

	localparam logic [addrW-1:0] resetPc = 32'hbfc0_0000; // Boot ROM entry in kseg1.
	localparam logic [addrW-1:0] pcStep = 32'd4;

	// Primary opcode field, bits 31:26 of the instruction word.
	typedef enum logic [5:0] {
		special = 6'd0,
		j = 6'd2,
		beq = 6'd4,
		addiu = 6'd9,
		lui = 6'd15,
		lw = 6'd35,
		sw = 6'd43
	} opcodeT;

	typedef enum logic [2:0] {
		classNone,
		classAlu,
		classLoad,
		classStore,
		classBranch,
		classJump
	} opClassT;

	// Values follow the CP0 Cause.ExcCode encoding.
	typedef enum logic [excW-1:0] {
		excNone = 5'd0,
		excAdEL = 5'd4,
		excRI = 5'd10
	} excCodeT;

endpackage

//--- hdl/pipeTop.sv
`timescale 1ns/100ps

module pipeTop (
	input logic clk,
	input logic rstN,
	input logic stall,
	input logic flush,
	input logic [pipePkg::addrW-1:0] instr,
	input logic [pipePkg::addrW-1:0] redirectPc,
	output logic [pipePkg::addrW-1:0] pc,
	output logic exValid,
	output logic [pipePkg::addrW-1:0] exPc,
	output pipePkg::opClassT exClass,
	output logic [pipePkg::regW-1:0] exRs,
	output logic [pipePkg::regW-1:0] exRt,
	output logic [pipePkg::regW-1:0] exRd,
	output logic [pipePkg::regW-1:0] exShamt,
	output logic [5:0] exFunc,
	output logic [15:0] exImm,
	output logic exExc,
	output pipePkg::excCodeT exExcCode,
	output logic exStall
);

	logic fetchExc;
	pipePkg::excCodeT fetchExcCode;

	logic decValid;
	logic [pipePkg::addrW-1:0] decPc;
	pipePkg::opcodeT decOp;
	logic [pipePkg::regW-1:0] decRs;
	logic [pipePkg::regW-1:0] decRt;
	logic [pipePkg::regW-1:0] decRd;
	logic [pipePkg::regW-1:0] decShamt;
	logic [5:0] decFunc;
	logic [15:0] decImm;
	logic decExc;
	pipePkg::excCodeT decExcCode;

	fetchStage fetch (
		.clk, .rstN, .stall, .flush, .redirectPc,
		.pc, .fetchExc, .fetchExcCode
	);

	decodeLatch decode (
		.clk, .rstN, .stall, .flush, .instr,
		.fetchPc(pc), // The fetch pc feeds the decode slot directly.
		.fetchExc, .fetchExcCode,
		.decValid, .decPc, .decOp, .decRs, .decRt, .decRd, .decShamt,
		.decFunc, .decImm, .decExc, .decExcCode
	);

	executeLatch execute (
		.clk, .rstN, .stall, .flush,
		.decValid, .decPc, .decOp, .decRs, .decRt, .decRd, .decShamt,
		.decFunc, .decImm, .decExc, .decExcCode,
		.exValid, .exPc, .exClass, .exRs, .exRt, .exRd, .exShamt,
		.exFunc, .exImm, .exExc, .exExcCode, .exStall
	);

endmodule

//--- tests/pipeTasks.svh
`ifndef pipeTasksSvh
`define pipeTasksSvh

function automatic logic [31:0] randomWord();
	pipePkg::opcodeT opTable [7];
	logic [31:0] r;
	opTable = '{pipePkg::special, pipePkg::j, pipePkg::beq, pipePkg::addiu,
		pipePkg::lui, pipePkg::lw, pipePkg::sw};
	r = $urandom();
	return {opTable[$urandom_range(0, 6)], r[25:0]};
endfunction

function automatic logic [31:0] fetchWord(input logic [31:0] addr);
	if (!instrMem.exists(addr)) begin
		instrMem[addr] = randomWord(); // Unseen addresses get a legal instruction.
	end
	return instrMem[addr];
endfunction

function automatic pipePkg::opClassT classOf(input logic [5:0] op);
	case (op)
		6'd0, 6'd9, 6'd15: return pipePkg::classAlu;
		6'd35: return pipePkg::classLoad;
		6'd43: return pipePkg::classStore;
		6'd4: return pipePkg::classBranch;
		6'd2: return pipePkg::classJump;
		default: return pipePkg::classNone;
	endcase
endfunction

// The fetch address error is older than the decode error.
function automatic pipePkg::excCodeT excOf(input logic [31:0] addr, input logic [31:0] word);
	if (addr[1:0] != 2'b00) return pipePkg::excAdEL;
	if (classOf(word[31:26]) == pipePkg::classNone) return pipePkg::excRI;
	return pipePkg::excNone;
endfunction

task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
	assert (actual === expected) else begin
		$display("FAIL %s expected %h actual %h at %0t", name, expected, actual, $time);
		errors++;
	end
endtask

task automatic checkOutputs();
	pipePkg::excCodeT code;
	code = excOf(expItemPc, expItemWord);
	checkValue("pc", pc, expPc);
	checkValue("exValid", 32'(exValid), 32'(expValid));
	checkValue("exStall", 32'(exStall), 32'(expStallMark));
	if (expValid) begin
		checkValue("exPc", exPc, expItemPc);
		checkValue("exClass", 32'(exClass), 32'(classOf(expItemWord[31:26])));
		checkValue("exRs", 32'(exRs), 32'(expItemWord[25:21]));
		checkValue("exRt", 32'(exRt), 32'(expItemWord[20:16]));
		checkValue("exRd", 32'(exRd), 32'(expItemWord[15:11]));
		checkValue("exShamt", 32'(exShamt), 32'(expItemWord[10:6]));
		checkValue("exFunc", 32'(exFunc), 32'(expItemWord[5:0]));
		checkValue("exImm", 32'(exImm), 32'(expItemWord[15:0]));
		checkValue("exExc", 32'(exExc), 32'(code != pipePkg::excNone));
		checkValue("exExcCode", 32'(exExcCode), 32'(code));
	end else begin
		checkValue("exExc", 32'(exExc), 32'd0); // A bubble never carries an exception.
	end
endtask

task automatic runCycle(input logic stallIn, input logic flushIn, input logic [31:0] target);
	logic [31:0] word;
	logic [63:0] item;
	stall = stallIn;
	flush = flushIn;
	redirectPc = target;
	word = fetchWord(expPc);
	@(posedge clk);
	#0.5;
	flush = 1'b0;
	if (flushIn) begin
		inFlight.delete();
		expPc = target;
		expValid = 1'b0;
		expStallMark = 1'b0;
	end else if (stallIn) begin
		expStallMark = 1'b1;
	end else begin
		inFlight.push_back({expPc, word});
		expStallMark = 1'b0;
		expValid = 1'b0;
		if (inFlight.size() > 1) begin
			item = inFlight.pop_front(); // Two edges after its fetch.
			expValid = 1'b1;
			expItemPc = item[63:32];
			expItemWord = item[31:0];
		end
		expPc = expPc + 32'd4;
	end
	instr = fetchWord(pc);
	checkOutputs();
endtask

task automatic testReset();
	checkValue("pc", pc, 32'hbfc0_0000);
	checkValue("exValid", 32'(exValid), 32'd0);
	checkValue("exStall", 32'(exStall), 32'd0);
	checkValue("exExc", 32'(exExc), 32'd0);
	checkValue("exExcCode", 32'(exExcCode), 32'(pipePkg::excNone));
endtask

task automatic testSequential();
	repeat (20) runCycle(1'b0, 1'b0, '0);
endtask

task automatic testStall();
	int holdCycles;
	holdCycles = $urandom_range(1, 5);
	repeat (holdCycles) runCycle(1'b1, 1'b0, '0);
	repeat (6) runCycle(1'b0, 1'b0, '0);
endtask

task automatic testFlush();
	logic [31:0] r;
	r = $urandom();
	runCycle(1'b0, 1'b1, {r[31:2], 2'b00});
	repeat (6) runCycle(1'b0, 1'b0, '0);
endtask

task automatic testReservedInstr();
	logic [31:0] r;
	logic [31:0] target;
	r = $urandom();
	target = {r[31:2], 2'b00};
	instrMem[target + 32'd8] = {6'h3f, r[25:0]};
	runCycle(1'b1, 1'b1, target); // Flush overrides the stall.
	repeat (6) runCycle(1'b0, 1'b0, '0);
endtask

task automatic testMisalignedFetch();
	logic [31:0] r;
	logic [31:0] target;
	r = $urandom();
	target = {r[31:2], 2'b10};
	instrMem[target] = {6'h3f, r[25:0]};
	runCycle(1'b0, 1'b1, target);
	repeat (4) runCycle(1'b0, 1'b0, '0);
endtask

`endif

//--- tests/pipeTb.sv
`timescale 1ns/100ps

module pipeTb;

	localparam int maxCycles = 400; // The directed tests need about 60 cycles.
	localparam logic [31:0] seed = 32'h16b1_ea53;

	logic clk;
	logic rstN;
	logic stall;
	logic flush;
	logic [31:0] instr;
	logic [31:0] redirectPc;
	logic [31:0] pc;
	logic exValid;
	logic [31:0] exPc;
	pipePkg::opClassT exClass;
	logic [4:0] exRs;
	logic [4:0] exRt;
	logic [4:0] exRd;
	logic [4:0] exShamt;
	logic [5:0] exFunc;
	logic [15:0] exImm;
	logic exExc;
	pipePkg::excCodeT exExcCode;
	logic exStall;

	int errors;
	int cycleCount = 0;

	logic [31:0] instrMem [logic [31:0]]; // Sparse program memory keyed by byte address.

	// Reference model of what the execute slot should show.
	logic [31:0] expPc;
	logic [63:0] inFlight [$];
	logic expValid;
	logic [31:0] expItemPc;
	logic [31:0] expItemWord;
	logic expStallMark;

	`include "pipeTasks.svh"

	pipeTop UUT (
		.clk, .rstN, .stall, .flush, .instr, .redirectPc, .pc,
		.exValid, .exPc, .exClass, .exRs, .exRt, .exRd, .exShamt,
		.exFunc, .exImm, .exExc, .exExcCode, .exStall
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= maxCycles) begin
			$display("The run hit the limit of %0d cycles before the tests finished.", maxCycles);
			$display("Some tests failed");
			$finish;
		end
	end

	initial begin
		void'($urandom(seed));
		clk = 1'b0;
		rstN = 1'b0;
		stall = 1'b0;
		flush = 1'b0;
		redirectPc = '0;
		instr = '0;
		errors = 0;
		expPc = pipePkg::resetPc;
		expValid = 1'b0;
		expItemPc = '0;
		expItemWord = '0;
		expStallMark = 1'b0;
		repeat (4) @(posedge clk);
		#0.5;
		rstN = 1'b1;
		instr = fetchWord(pc);
		testReset();
		testSequential();
		testStall();
		testFlush();
		testReservedInstr();
		testMisalignedFetch();
		$display("Run finished with %0d errors.", errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

//--- verilog.f
+incdir+tests
hdl/pipePkg.sv
hdl/fetchStage.sv
hdl/decodeLatch.sv
hdl/executeLatch.sv
hdl/pipeTop.sv
tests/pipeTb.sv
